//--- verilog.f
common/mmu_pkg.sv
common/apb_pkg.sv
design/itlb/itlb_ram.sv
design/itlb/itlb.sv
design/walker/page_walker.sv
design/apb_ctrl.sv
design/itrans_top.sv
verif/itrans_assertions.sv
verif/itrans_tb.sv

//--- verif/itrans_tb.sv
// Testbench for the instruction translation subsystem
// Loads the page table over APB, then runs a stimulus table of fetches,
// PTE rewrites and sfence operations against a page table copy

module itrans_tb;

    localparam int PT_ENTRIES = 64;
    localparam int PT_BASE    = 8;                      // Nonzero base, exercises the wrap
    localparam int ASID       = 5;
    localparam int TIMEOUT    = 20;
    localparam logic [31:0] RND_PAGE = 32'h0000_a000;   // TLB index 10 for random pages

    typedef enum {ACT_NONE, ACT_PTE, ACT_SFENCE} act_e;
    typedef struct {
        act_e                          act;
        apb_pkg::sfence_mode_e         mode;
        logic [31:0]                   arg;         // New PTE or sfence address
        logic [mmu_pkg::VA_W-1:0]      vaddr;
        logic [mmu_pkg::PA_W-1:0]      exp_paddr;
        logic                          exp_fault;
        int                            exp_lat;     // Negative means any latency
    } row_t;

    logic clk, rst, psel, penable, pwrite, pready, req_valid, req_ready, rsp_valid, rsp_fault;
    logic [apb_pkg::ADDR_W-1:0] paddr;
    logic [apb_pkg::DATA_W-1:0] pwdata, prdata, rd_data;
    logic [mmu_pkg::VA_W-1:0]   req_vaddr, va;
    logic [mmu_pkg::PA_W-1:0]   rsp_paddr, got_paddr;
    logic                       got_fault;
    logic [mmu_pkg::PTE_W-1:0]  pt_model [PT_ENTRIES];  // Copy of the walk memory
    logic [mmu_pkg::PTE_W-1:0]  old_pte;
    row_t   rows[$];
    integer seed;
    int     errors, err_before, got_lat, rows_run;
    bit     timed_out;

    itrans_top #(.WAYS(2), .DEPTH(16), .PT_ENTRIES(PT_ENTRIES)) dut_i (.*);

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Model helpers
    function automatic int pt_index(input logic [mmu_pkg::VA_W-1:0] addr);
        return (PT_BASE + int'(addr >> mmu_pkg::PAGE_OFF_W)) % PT_ENTRIES;
    endfunction

    function automatic logic [31:0] mk_pte(input logic [19:0] ppn, input logic v, x, g);
        logic [31:0] pte;
        pte = '0;
        pte[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPN_W] = ppn;
        pte[mmu_pkg::PTE_V] = v;
        pte[mmu_pkg::PTE_X] = x;
        pte[mmu_pkg::PTE_G] = g;
        return pte;
    endfunction

    function automatic logic [31:0] pte_of(input logic [mmu_pkg::VA_W-1:0] addr);
        return pt_model[pt_index(addr)];
    endfunction

    // Expected result from the PTE the fetch should see
    function automatic void add_row(input act_e act, input apb_pkg::sfence_mode_e mode,
                                    input logic [31:0] arg, input logic [31:0] addr,
                                    input logic [31:0] exp_pte, input int lat);
        row_t r;
        r.act       = act;
        r.mode      = mode;
        r.arg       = arg;
        r.vaddr     = addr;
        r.exp_lat   = lat;
        r.exp_paddr = {exp_pte[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPN_W], addr[11:0]};
        r.exp_fault = !(exp_pte[mmu_pkg::PTE_V] && exp_pte[mmu_pkg::PTE_X]);
        if (act == ACT_PTE) begin
            pt_model[pt_index(addr)] = arg;     // Later rows see the rewrite
        end
        rows.push_back(r);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Bus tasks, entered 1 unit after a rising edge
    task automatic apb_write(input logic [apb_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
        int cyc;
        cyc     = 0;
        psel    = 1;                            // Setup phase
        penable = 0;
        pwrite  = 1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1;
        @(negedge clk);
        while (!pready && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!pready) begin
            $display("timeout: pready stuck low at address %h", addr);
            timed_out = 1;
        end
        @(posedge clk);
        #1 psel = 0;
        penable = 0;
        pwrite  = 0;
    endtask

    // Read data sampled mid access phase
    task automatic apb_read(input logic [apb_pkg::ADDR_W-1:0] addr,
                            output logic [apb_pkg::DATA_W-1:0] data);
        int cyc;
        cyc     = 0;
        psel    = 1;
        penable = 0;
        pwrite  = 0;
        paddr   = addr;
        @(posedge clk);
        #1 penable = 1;
        @(negedge clk);
        while (!pready && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!pready) begin
            $display("timeout: pready stuck low at address %h", addr);
            timed_out = 1;
        end
        data = prdata;
        @(posedge clk);
        #1 psel = 0;
        penable = 0;
    endtask

    // Holds the request until a response, latency counted from acceptance
    task automatic fetch(input logic [31:0] addr, output logic [mmu_pkg::PA_W-1:0] pa,
                         output logic flt, output int lat);
        int cyc, acc;
        bit done;
        cyc       = 0;
        acc       = -1;
        done      = 0;
        req_valid = 1;
        req_vaddr = addr;
        while (!done && cyc < TIMEOUT) begin
            @(negedge clk);
            if (acc < 0 && req_ready) acc = cyc;
            if (rsp_valid) begin
                done = 1;
                lat  = cyc - acc;
                pa   = rsp_paddr;
                flt  = rsp_fault;
            end
            @(posedge clk);
            #1 cyc++;
        end
        req_valid = 0;
        if (!done) begin
            $display("timeout: no response for vaddr %h", addr);
            timed_out = 1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_paddr(input int row, input logic [mmu_pkg::PA_W-1:0] got, exp);
        if (got !== exp) begin
            $display("mismatch at %0t: row %0d paddr %h, expected %h", $time, row, got, exp);
            errors++;
        end
    endtask

    task automatic check_fault(input int row, input logic got, exp);
        if (got !== exp) begin
            $display("mismatch at %0t: row %0d fault %b, expected %b", $time, row, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input int row, input int got, exp);
        if (got != exp) begin
            $display("mismatch at %0t: row %0d latency %0d, expected %0d", $time, row, got, exp);
            errors++;
        end
    endtask

    task automatic check_prdata(input logic [apb_pkg::ADDR_W-1:0] addr,
                                input logic [apb_pkg::DATA_W-1:0] got, exp);
        if (got !== exp) begin
            $display("mismatch at %0t: read %h gave %h, expected %h", $time, addr, got, exp);
            errors++;
        end
    endtask

    initial begin
        seed = 32'h54b87414;
        {clk, psel, penable, pwrite, req_valid} = '0;
        {paddr, pwdata, req_vaddr} = '0;
        rst       = 1;
        errors    = 0;
        rows_run  = 0;
        timed_out = 0;
        repeat (8) @(posedge clk);
        #1 rst = 0;

        // Pages 1..7, page 2 lacks X, page 3 lacks V, page 4 global
        for (int p = 0; p < PT_ENTRIES; p++) pt_model[p] = '0;
        for (int p = 1; p < 8; p++) begin
            pt_model[pt_index(p << 12)] = mk_pte(20'(p * 20'h11111), p != 3, p != 2, p == 4);
        end
        for (int k = 0; k < 4; k++) begin
            pt_model[pt_index(RND_PAGE | (k << 16))] = mk_pte(20'($random(seed)), 1, 1, 0);
        end
        apb_write(apb_pkg::REG_BASE, PT_BASE);
        apb_write(apb_pkg::REG_ASID, ASID);
        for (int d = 0; d < 16; d++) begin          // TLB not cleared by reset
            apb_write(apb_pkg::REG_SFENCE_ADDR, d << 12);
            apb_write(apb_pkg::REG_SFENCE, apb_pkg::SFENCE_ALL);
        end
        for (int p = 0; p < PT_ENTRIES; p++) apb_write(apb_pkg::REG_MEM + 4 * p, pt_model[p]);

        // Register and walk memory readback
        err_before = errors;
        apb_read(apb_pkg::REG_BASE, rd_data);
        check_prdata(apb_pkg::REG_BASE, rd_data, PT_BASE);
        apb_read(apb_pkg::REG_ASID, rd_data);
        check_prdata(apb_pkg::REG_ASID, rd_data, ASID);
        apb_read(apb_pkg::REG_SFENCE_ADDR, rd_data);
        check_prdata(apb_pkg::REG_SFENCE_ADDR, rd_data, 32'h0000_f000);
        for (int p = 0; p < PT_ENTRIES; p++) begin
            apb_read(apb_pkg::REG_MEM + 4 * p, rd_data);
            check_prdata(apb_pkg::REG_MEM + 4 * p, rd_data, pt_model[p]);
        end
        $display("readback %s", errors == err_before ? "ok" : "wrong");

        // Miss then hit, faults leave no entry
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h1000, pte_of(32'h1000), 4);
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h1234, pte_of(32'h1000), 0);
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h2000, pte_of(32'h2000), 3);
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h2000, pte_of(32'h2000), 3);
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h3000, pte_of(32'h3000), 3);
        // Rewrite stays hidden until sfence all
        add_row(ACT_PTE, apb_pkg::SFENCE_ALL, mk_pte(20'h0abcd, 1, 1, 0), 32'h1000,
                pte_of(32'h1000), 0);
        add_row(ACT_SFENCE, apb_pkg::SFENCE_ALL, 32'h1000, 32'h1000, pte_of(32'h1000), 4);
        // sfence asid drops page 5, keeps global page 4
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h4000, pte_of(32'h4000), 4);
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h5000, pte_of(32'h5000), 4);
        old_pte = pte_of(32'h4000);
        add_row(ACT_PTE, apb_pkg::SFENCE_ALL, mk_pte(20'h4a4a4, 1, 1, 1), 32'h4000, old_pte, 0);
        add_row(ACT_SFENCE, apb_pkg::SFENCE_ASID, 32'h4000, 32'h4000, old_pte, 0);
        add_row(ACT_PTE, apb_pkg::SFENCE_ALL, mk_pte(20'h5a5a5, 1, 1, 0), 32'h5000,
                pte_of(32'h5000), 0);
        add_row(ACT_SFENCE, apb_pkg::SFENCE_ASID, 32'h5000, 32'h5000, pte_of(32'h5000), 4);
        // sfence addr, other tag in the same set survives
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h6000, pte_of(32'h6000), 4);
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h7000, pte_of(32'h7000), 4);
        add_row(ACT_SFENCE, apb_pkg::SFENCE_ADDR, 32'h1_7000, 32'h7000, pte_of(32'h7000), 0);
        add_row(ACT_SFENCE, apb_pkg::SFENCE_ADDR, 32'h6000, 32'h7000, pte_of(32'h7000), 0);
        add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, 32'h6000, pte_of(32'h6000), 4);
        // Four tags on one index, two ways, so evictions
        for (int k = 0; k < 10; k++) begin
            va = ($random(seed) & 32'h0003_0fff) | RND_PAGE;
            add_row(ACT_NONE, apb_pkg::SFENCE_ALL, 0, va, pte_of(va), -1);
        end

        //////////////////////////////////////////////////////////////////////
        // Apply the table
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            err_before = errors;
            case (rows[i].act)
                ACT_PTE: apb_write(apb_pkg::REG_MEM + 4 * pt_index(rows[i].vaddr), rows[i].arg);
                ACT_SFENCE: begin
                    apb_write(apb_pkg::REG_SFENCE_ADDR, rows[i].arg);
                    apb_write(apb_pkg::REG_SFENCE, 32'(rows[i].mode));
                end
                default: ;
            endcase
            fetch(rows[i].vaddr, got_paddr, got_fault, got_lat);
            if (!timed_out) begin
                rows_run++;
                check_fault(i, got_fault, rows[i].exp_fault);
                if (!rows[i].exp_fault) check_paddr(i, got_paddr, rows[i].exp_paddr);
                if (rows[i].exp_lat >= 0) check_latency(i, got_lat, rows[i].exp_lat);
                $display("row %0d vaddr %h %s", i, rows[i].vaddr,
                         errors == err_before ? "ok" : "wrong");
            end
        end

        $display("rows run %0d of %0d, errors %0d", rows_run, rows.size(), errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/itrans_assertions.sv
// TLB handshake checks
// Bound into the instruction TLB, watches response source and walk handshake

module itrans_assertions #(
    parameter int WAYS = 2
) (
    input logic            clk,
    input logic            rst,
    input logic            rsp_valid,
    input logic            fault,
    input logic            refill,
    input logic            walk_req,
    input logic [WAYS-1:0] tag_hit
);

    // A response comes from exactly one way, or from the walker fault
    rsp_one_source: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> ($onehot(tag_hit) || fault))
        else $error("rsp_valid without a single hit way or a fault");

    // Walker answers only a pending walk
    walk_answer_pending: assert property (@(posedge clk) disable iff (rst)
        (refill || fault) |-> walk_req)
        else $error("refill or fault without a pending walk");

    // Walker ends a walk one way only
    refill_or_fault: assert property (@(posedge clk) disable iff (rst)
        !(refill && fault))
        else $error("refill and fault high in the same cycle");

endmodule

bind itlb itrans_assertions #(.WAYS(WAYS)) itlb_checks (
    .clk(clk), .rst(rst), .rsp_valid(rsp_valid), .fault(fault), .refill(refill),
    .walk_req(walk_req), .tag_hit(tag_hit)
);

//--- design/itrans_top.sv
// Instruction address translation top level
// APB control, instruction TLB and page walker

module itrans_top #(
    parameter int WAYS       = 2,
    parameter int DEPTH      = 16,
    parameter int PT_ENTRIES = 64
) (
    input  logic                        clk,
    input  logic                        rst,
    // APB slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [apb_pkg::ADDR_W-1:0]  paddr,
    input  logic [apb_pkg::DATA_W-1:0]  pwdata,
    output logic [apb_pkg::DATA_W-1:0]  prdata,
    output logic                        pready,
    // Fetch port
    input  logic                        req_valid,
    input  logic [mmu_pkg::VA_W-1:0]    req_vaddr,
    output logic                        req_ready,
    output logic                        rsp_valid,
    output logic [mmu_pkg::PA_W-1:0]    rsp_paddr,
    output logic                        rsp_fault
);

    localparam int PT_IDX_W = $clog2(PT_ENTRIES);

    logic [PT_IDX_W-1:0]          pt_base;
    logic [mmu_pkg::ASID_W-1:0]   asid;
    logic                         sfence_valid;
    apb_pkg::sfence_mode_e        sfence_mode;
    logic [mmu_pkg::VA_W-1:0]     sfence_addr;
    logic [PT_IDX_W-1:0]          mem_raddr;
    logic [mmu_pkg::PTE_W-1:0]    mem_rdata;
    logic                         walk_req;
    logic [mmu_pkg::VA_W-1:0]     walk_vaddr;
    logic                         refill;
    logic [mmu_pkg::PPN_W-1:0]    refill_ppn;
    logic                         refill_global;
    logic                         fault;

    //////////////////////////////////////////////////////////////////////
    apb_ctrl #(.PT_ENTRIES(PT_ENTRIES)) apb_ctrl_i (
        .clk, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .pt_base, .asid,
        .sfence_valid, .sfence_mode, .sfence_addr,
        .mem_raddr, .mem_rdata
    );

    // Lookup stage
    itlb #(.WAYS(WAYS), .DEPTH(DEPTH)) itlb_i (
        .clk, .rst,
        .req_valid, .req_vaddr, .req_ready,
        .rsp_valid, .rsp_paddr, .rsp_fault,
        .asid,
        .sfence_valid, .sfence_mode, .sfence_addr,
        .walk_req, .walk_vaddr,
        .refill, .refill_ppn, .refill_global, .fault
    );

    // Walk stage
    page_walker #(.PT_ENTRIES(PT_ENTRIES)) walker_i (
        .clk, .rst,
        .walk_req, .walk_vaddr,
        .pt_base,
        .mem_raddr, .mem_rdata,
        .refill, .refill_ppn, .refill_global, .fault
    );

endmodule

//--- design/apb_ctrl.sv
// APB slave for the translation subsystem
// Holds page table base and ASID, issues sfence pulses and owns
// the walk memory (APB write and read, registered walker read)

module apb_ctrl #(
    parameter int PT_ENTRIES = 64
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [apb_pkg::ADDR_W-1:0]      paddr,
    input  logic [apb_pkg::DATA_W-1:0]      pwdata,
    output logic [apb_pkg::DATA_W-1:0]      prdata,
    output logic                            pready,
    output logic [$clog2(PT_ENTRIES)-1:0]   pt_base,
    output logic [mmu_pkg::ASID_W-1:0]      asid,
    output logic                            sfence_valid,
    output apb_pkg::sfence_mode_e           sfence_mode,
    output logic [mmu_pkg::VA_W-1:0]        sfence_addr,
    input  logic [$clog2(PT_ENTRIES)-1:0]   mem_raddr,
    output logic [mmu_pkg::PTE_W-1:0]       mem_rdata
);

    localparam int PT_IDX_W = $clog2(PT_ENTRIES);

    logic [mmu_pkg::PTE_W-1:0] pt_mem [PT_ENTRIES];
    logic                      wr_en;
    logic                      mem_sel;
    logic [PT_IDX_W-1:0]       mem_idx;

    assign pready  = 1'b1;                          // No wait states
    assign wr_en   = psel & penable & pwrite;       // Access phase
    assign mem_sel = paddr >= apb_pkg::REG_MEM &&
                     paddr <  apb_pkg::REG_MEM + 4 * PT_ENTRIES;
    assign mem_idx = paddr[2 +: PT_IDX_W];          // Word index in the window

    //////////////////////////////////////////////////////////////////////
    // Control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            pt_base      <= '0;
            asid         <= '0;
            sfence_valid <= 1'b0;
            sfence_mode  <= apb_pkg::SFENCE_ALL;
        end else begin
            sfence_valid <= wr_en && paddr == apb_pkg::REG_SFENCE;     // Single pulse
            if (wr_en) begin
                case (paddr)
                    apb_pkg::REG_BASE:   pt_base     <= pwdata[PT_IDX_W-1:0];
                    apb_pkg::REG_ASID:   asid        <= pwdata[mmu_pkg::ASID_W-1:0];
                    apb_pkg::REG_SFENCE: sfence_mode <= apb_pkg::sfence_mode_e'(pwdata[1:0]);
                    default: ;
                endcase
            end
        end
    end

    // sfence target address
    always_ff @(posedge clk) begin
        if (wr_en && paddr == apb_pkg::REG_SFENCE_ADDR) begin
            sfence_addr <= pwdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Walk memory
    always_ff @(posedge clk) begin
        if (wr_en && mem_sel) begin
            pt_mem[mem_idx] <= pwdata;
        end
        mem_rdata <= pt_mem[mem_raddr];             // Walker sees data next cycle
    end

    // Read mux
    always_comb begin
        case (paddr)
            apb_pkg::REG_BASE:        prdata = apb_pkg::DATA_W'(pt_base);
            apb_pkg::REG_ASID:        prdata = apb_pkg::DATA_W'(asid);
            apb_pkg::REG_SFENCE:      prdata = apb_pkg::DATA_W'(sfence_mode);
            apb_pkg::REG_SFENCE_ADDR: prdata = sfence_addr;
            default:                  prdata = mem_sel ? pt_mem[mem_idx] : '0;
        endcase
    end

endmodule

//--- design/walker/page_walker.sv
// Single-level Sv32 page walker
// Reads one PTE from the walk memory and returns a refill or a fault

module page_walker #(
    parameter int PT_ENTRIES = 64
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            walk_req,
    input  logic [mmu_pkg::VA_W-1:0]        walk_vaddr,
    input  logic [$clog2(PT_ENTRIES)-1:0]   pt_base,
    output logic [$clog2(PT_ENTRIES)-1:0]   mem_raddr,
    input  logic [mmu_pkg::PTE_W-1:0]       mem_rdata,
    output logic                            refill,
    output logic [mmu_pkg::PPN_W-1:0]       refill_ppn,
    output logic                            refill_global,
    output logic                            fault
);

    localparam int PT_IDX_W = $clog2(PT_ENTRIES);

    mmu_pkg::walk_state_e state;
    mmu_pkg::walk_state_e state_next;
    logic                 pte_ok;
    logic [mmu_pkg::PPN_W-1:0] ppn_q;
    logic                 global_q;

    // PTE index wraps inside the table
    assign mem_raddr = pt_base + walk_vaddr[mmu_pkg::PAGE_OFF_W +: PT_IDX_W];

    // Only V and X are checked
    assign pte_ok = mem_rdata[mmu_pkg::PTE_V] & mem_rdata[mmu_pkg::PTE_X];

    //////////////////////////////////////////////////////////////////////
    // FSM
    always_comb begin
        state_next = state;
        case (state)
            mmu_pkg::WALK_IDLE:   state_next = mmu_pkg::WALK_READ;    // Prime the read port
            mmu_pkg::WALK_READ: begin
                if (walk_req) begin
                    state_next = mmu_pkg::WALK_CHECK;
                end
            end
            mmu_pkg::WALK_CHECK:  state_next = pte_ok ? mmu_pkg::WALK_REFILL
                                                      : mmu_pkg::WALK_FAULT;
            mmu_pkg::WALK_REFILL: state_next = mmu_pkg::WALK_READ;
            mmu_pkg::WALK_FAULT:  state_next = mmu_pkg::WALK_READ;
            default:              state_next = mmu_pkg::WALK_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mmu_pkg::WALK_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Capture the PTE fields for the refill cycle
    always_ff @(posedge clk) begin
        if (state == mmu_pkg::WALK_CHECK) begin
            ppn_q    <= mem_rdata[mmu_pkg::PTE_PPN_LSB +: mmu_pkg::PPN_W];
            global_q <= mem_rdata[mmu_pkg::PTE_G];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs, one-cycle pulses
    assign refill        = state == mmu_pkg::WALK_REFILL;
    assign fault         = state == mmu_pkg::WALK_FAULT;
    assign refill_ppn    = ppn_q;
    assign refill_global = global_q;

endmodule

//--- design/itlb/itlb.sv
// Instruction TLB
// Set-associative lookup with combinational hit, sfence invalidation
// per index and random-replacement refill from the page walker

module itlb #(
    parameter int WAYS  = 2,
    parameter int DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    // Fetch side
    input  logic                         req_valid,
    input  logic [mmu_pkg::VA_W-1:0]     req_vaddr,
    output logic                         req_ready,
    output logic                         rsp_valid,
    output logic [mmu_pkg::PA_W-1:0]     rsp_paddr,
    output logic                         rsp_fault,
    input  logic [mmu_pkg::ASID_W-1:0]   asid,
    // Invalidation
    input  logic                         sfence_valid,
    input  apb_pkg::sfence_mode_e        sfence_mode,
    input  logic [mmu_pkg::VA_W-1:0]     sfence_addr,
    // Walker
    output logic                         walk_req,
    output logic [mmu_pkg::VA_W-1:0]     walk_vaddr,
    input  logic                         refill,
    input  logic [mmu_pkg::PPN_W-1:0]    refill_ppn,
    input  logic                         refill_global,
    input  logic                         fault
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int TAG_W = mmu_pkg::VA_W - mmu_pkg::PAGE_OFF_W - IDX_W;

    typedef struct packed {
        logic                       valid;
        logic                       is_global;
        logic [mmu_pkg::ASID_W-1:0] asid;
        logic [TAG_W-1:0]           tag;
        logic [mmu_pkg::PPN_W-1:0]  ppn;
    } entry_t;

    logic [IDX_W-1:0] tlb_idx;
    logic [TAG_W-1:0] req_tag;
    logic [TAG_W-1:0] sfence_tag;
    entry_t           rd_entry [WAYS];
    entry_t           wr_entry;
    logic [WAYS-1:0]  way_we;
    logic [WAYS-1:0]  tag_hit;
    logic [WAYS-1:0]  asid_match;
    logic [WAYS-1:0]  addr_match;
    logic [WAYS-1:0]  repl_way;
    logic             hit;
    logic [mmu_pkg::PPN_W-1:0] hit_ppn;
    logic             walk_pending;
    logic             refill_done;

    //////////////////////////////////////////////////////////////////////
    // Storage
    generate
        for (genvar i = 0; i < WAYS; i++) begin : g_way
            itlb_ram #(.WIDTH($bits(entry_t)), .DEPTH(DEPTH)) way_ram (
                .clk   (clk),
                .waddr (tlb_idx),
                .raddr (tlb_idx),
                .we    (way_we[i]),
                .wdata (wr_entry),
                .rdata (rd_entry[i])
            );
        end
    endgenerate

    // sfence works on one index per pulse, taken from its address
    assign tlb_idx    = sfence_valid ? sfence_addr[mmu_pkg::PAGE_OFF_W +: IDX_W]
                                     : req_vaddr[mmu_pkg::PAGE_OFF_W +: IDX_W];
    assign req_tag    = req_vaddr[mmu_pkg::VA_W-1 -: TAG_W];
    assign sfence_tag = sfence_addr[mmu_pkg::VA_W-1 -: TAG_W];

    //////////////////////////////////////////////////////////////////////
    // Hit detection
    always_comb begin
        hit_ppn = '0;
        for (int i = 0; i < WAYS; i++) begin
            tag_hit[i] = rd_entry[i].valid && rd_entry[i].tag == req_tag &&
                         (rd_entry[i].is_global || rd_entry[i].asid == asid);
            if (tag_hit[i]) begin
                hit_ppn |= rd_entry[i].ppn;     // One-hot, so OR is a mux
            end
        end
    end
    assign hit = |tag_hit;

    //////////////////////////////////////////////////////////////////////
    // Write enables, sfence has priority over refill
    assign wr_entry = '{
        valid:     ~sfence_valid,               // sfence writes an invalid entry
        is_global: refill_global,
        asid:      asid,
        tag:       req_tag,
        ppn:       refill_ppn
    };

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            asid_match[i] = ~rd_entry[i].is_global && rd_entry[i].asid == asid;
            addr_match[i] = rd_entry[i].tag == sfence_tag;
            way_we[i]     = 1'b0;
            if (sfence_valid) begin
                case (sfence_mode)
                    apb_pkg::SFENCE_ALL:       way_we[i] = 1'b1;
                    apb_pkg::SFENCE_ASID:      way_we[i] = asid_match[i];
                    apb_pkg::SFENCE_ADDR:      way_we[i] = addr_match[i];
                    apb_pkg::SFENCE_ASID_ADDR: way_we[i] = asid_match[i] & addr_match[i];
                    default:                   way_we[i] = 1'b0;
                endcase
            end else begin
                way_we[i] = refill & repl_way[i];
            end
        end
    end

    // Free-running one-hot rotator as the random victim pick
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= {{(WAYS-1){1'b0}}, 1'b1};
        end else begin
            repl_way <= {repl_way[WAYS-2:0], repl_way[WAYS-1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Miss handling
    always_ff @(posedge clk) begin
        if (rst) begin
            walk_pending <= 1'b0;
            refill_done  <= 1'b0;
        end else begin
            if (refill || fault) begin
                walk_pending <= 1'b0;
            end else if (req_valid && req_ready && !hit) begin
                walk_pending <= 1'b1;
            end
            refill_done <= refill;              // Re-lookup cycle after the write
        end
    end

    assign walk_req   = walk_pending;
    assign walk_vaddr = req_vaddr;              // Requester holds it while stalled

    // Fetch response
    assign req_ready = ~walk_pending & ~sfence_valid;
    assign rsp_valid = (hit && ((req_valid && req_ready) || refill_done)) || fault;
    assign rsp_fault = fault;
    assign rsp_paddr = {hit_ppn, req_vaddr[mmu_pkg::PAGE_OFF_W-1:0]};

endmodule

//--- design/itlb/itlb_ram.sv
// One TLB way
// Single write port, single asynchronous read port, LUT RAM style

module itlb_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic                     we,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];      // Contents undefined until sfence

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Combinational read
    assign rdata = mem[raddr];

endmodule

//--- common/apb_pkg.sv
// APB register map of the translation subsystem
// Also the sfence mode encoding

package apb_pkg;

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    // Register offsets
    localparam logic [ADDR_W-1:0] REG_BASE        = 12'h000;   // Page table base index
    localparam logic [ADDR_W-1:0] REG_ASID        = 12'h004;
    localparam logic [ADDR_W-1:0] REG_SFENCE      = 12'h008;   // Write issues sfence
    localparam logic [ADDR_W-1:0] REG_SFENCE_ADDR = 12'h00c;
    localparam logic [ADDR_W-1:0] REG_MEM         = 12'h100;   // Walk memory window start

    // sfence modes, bits 1:0 of a REG_SFENCE write
    typedef enum logic [1:0] {
        SFENCE_ALL,
        SFENCE_ASID,
        SFENCE_ADDR,
        SFENCE_ASID_ADDR
    } sfence_mode_e;

endpackage

//--- common/mmu_pkg.sv
// Sv32 instruction translation definitions
// Address widths, PTE field positions and walker states

package mmu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address widths
    localparam int VA_W       = 32;
    localparam int PAGE_OFF_W = 12;                 // 4 KiB pages only
    localparam int PPN_W      = 20;
    localparam int PA_W       = PPN_W + PAGE_OFF_W;
    localparam int ASID_W     = 9;

    //////////////////////////////////////////////////////////////////////
    // Page table entry layout
    localparam int PTE_W       = 32;
    localparam int PTE_V       = 0;                 // Valid
    localparam int PTE_X       = 3;                 // Execute
    localparam int PTE_G       = 5;                 // Global mapping
    localparam int PTE_PPN_LSB = 10;                // Low 20 bits of Sv32 PPN field

    // Walker FSM
    typedef enum logic [2:0] {
        WALK_IDLE,      // Out of reset
        WALK_READ,      // PTE address on the memory port
        WALK_CHECK,     // PTE back, test V and X
        WALK_REFILL,    // One cycle TLB write
        WALK_FAULT      // One cycle fault report
    } walk_state_e;

endpackage
